/* rtl/cpuTypesPkg.sv */
// shared word and field types for the pipelined cpu
// opcode, funct, alu control and forwarding select codes
package cpuTypesPkg;

  typedef logic [31:0] wordT;     // data, address or instruction
  typedef logic [4:0]  regAddrT;  // register number
  typedef logic [5:0]  opcodeT;
  typedef logic [5:0]  functT;
  typedef logic [2:0]  aluCtlT;
  typedef logic [1:0]  fwdSelT;

  // opcodes
  localparam opcodeT opRtype = 6'h00;
  localparam opcodeT opJ     = 6'h02;
  localparam opcodeT opBeq   = 6'h04;
  localparam opcodeT opBne   = 6'h05;
  localparam opcodeT opAddiu = 6'h09;
  localparam opcodeT opLui   = 6'h0F;
  localparam opcodeT opLw    = 6'h23;
  localparam opcodeT opSw    = 6'h2B;
  localparam opcodeT opHalt  = 6'h3F;

  // r-type funct codes
  localparam functT fnAddu = 6'h21;
  localparam functT fnSubu = 6'h23;
  localparam functT fnAnd  = 6'h24;
  localparam functT fnOr   = 6'h25;
  localparam functT fnSlt  = 6'h2A;

  // alu operations
  localparam aluCtlT aluAdd = 3'd0;
  localparam aluCtlT aluSub = 3'd1;
  localparam aluCtlT aluAnd = 3'd2;
  localparam aluCtlT aluOr  = 3'd3;
  localparam aluCtlT aluSlt = 3'd4;
  localparam aluCtlT aluLui = 3'd5;  // passes operand b, already shifted

  // forwarding sources for the execute operands
  localparam fwdSelT fwdNone  = 2'd0;
  localparam fwdSelT fwdExMem = 2'd1;
  localparam fwdSelT fwdMemWb = 2'd2;

endpackage

/* rtl/regFile.sv */
// 32-entry register file, two read ports, one write port
`timescale 1ns/1ns

module regFile (
  input  logic                 CLK,
  input  logic                 nRST,
  input  cpuTypesPkg::regAddrT rs,
  input  cpuTypesPkg::regAddrT rt,
  input  cpuTypesPkg::regAddrT wbReg,
  input  logic                 wbWrite,
  input  cpuTypesPkg::wordT    wbData,
  output cpuTypesPkg::wordT    rData1,
  output cpuTypesPkg::wordT    rData2
);

  cpuTypesPkg::wordT regs [32];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wbWrite && wbReg != '0)
      regs[wbReg] <= wbData;
  end

  // write-first, so write-back is visible to decode in the same cycle
  assign rData1 = (rs == '0) ? '0 :
                  (wbWrite && wbReg == rs) ? wbData : regs[rs];
  assign rData2 = (rt == '0) ? '0 :
                  (wbWrite && wbReg == rt) ? wbData : regs[rt];

endmodule

/* rtl/fetchStage.sv */
// program counter, next-pc selection, halt latch and IF/ID register
`timescale 1ns/1ns

module fetchStage #(
  parameter cpuTypesPkg::wordT resetPc = '0
) (
  input  logic              CLK,
  input  logic              nRST,
  output cpuTypesPkg::wordT iAddr,
  input  cpuTypesPkg::wordT iData,
  input  logic              stall,
  input  logic              flushIfId,
  input  logic              jumpTaken,
  input  logic              branchTaken,
  input  logic              haltSeen,
  input  cpuTypesPkg::wordT jumpTarget,
  input  cpuTypesPkg::wordT branchTarget,
  output cpuTypesPkg::wordT ifidInstr,
  output cpuTypesPkg::wordT ifidPcPlus4
);

  cpuTypesPkg::wordT pc;
  cpuTypesPkg::wordT pcPlus4;
  logic              stop;  // set once a halt has been decoded

  assign iAddr   = pc;
  assign pcPlus4 = pc + 32'd4;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      pc          <= resetPc;
      stop        <= 1'b0;
      ifidInstr   <= '0;
      ifidPcPlus4 <= '0;
    end
    else
    begin
      if (branchTaken)
        pc <= branchTarget;  // branch wins over everything
      else if (jumpTaken && !stall)
        pc <= jumpTarget;
      else if (!(stall || haltSeen || stop))
        pc <= pcPlus4;

      if (branchTaken)
        stop <= 1'b0;  // the halt in decode is being squashed
      else if (haltSeen && !stall)
        stop <= 1'b1;

      if (flushIfId || ((haltSeen || stop) && !stall))
      begin
        ifidInstr   <= '0;  // all-zero word is a no-op
        ifidPcPlus4 <= '0;
      end
      else if (!stall)
      begin
        ifidInstr   <= iData;
        ifidPcPlus4 <= pcPlus4;
      end
    end
  end

endmodule

/* rtl/decodeStage.sv */
// instruction decode, immediate extension, jump resolution
// and the ID/EX pipeline register
`timescale 1ns/1ns

module decodeStage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  cpuTypesPkg::wordT    ifidInstr,
  input  cpuTypesPkg::wordT    ifidPcPlus4,
  input  logic                 stall,
  input  logic                 flushIdEx,
  input  logic                 wbWrite,
  input  cpuTypesPkg::regAddrT wbReg,
  input  cpuTypesPkg::wordT    wbData,
  output cpuTypesPkg::regAddrT ifidRs,
  output cpuTypesPkg::regAddrT ifidRt,
  output logic                 jumpTaken,
  output logic                 haltSeen,
  output cpuTypesPkg::wordT    jumpTarget,
  output cpuTypesPkg::aluCtlT  idexAluCtl,
  output logic                 idexAluSrc,
  output logic                 idexRegWrite,
  output logic                 idexMemToReg,
  output logic                 idexDREN,
  output logic                 idexDWEN,
  output logic                 idexBeq,
  output logic                 idexBne,
  output logic                 idexHalt,
  output cpuTypesPkg::regAddrT idexRs,
  output cpuTypesPkg::regAddrT idexRt,
  output cpuTypesPkg::regAddrT idexDst,
  output cpuTypesPkg::wordT    idexRdat1,
  output cpuTypesPkg::wordT    idexRdat2,
  output cpuTypesPkg::wordT    idexImm,
  output cpuTypesPkg::wordT    idexPcPlus4
);

  cpuTypesPkg::opcodeT  opcode;
  cpuTypesPkg::functT   funct;
  cpuTypesPkg::regAddrT rd;
  cpuTypesPkg::wordT    rData1, rData2, imm;
  cpuTypesPkg::aluCtlT  aluCtl;
  cpuTypesPkg::regAddrT dst;
  logic aluSrc, regWrite, memToReg, dREN, dWEN, beq, bne;

  assign opcode = ifidInstr[31:26];
  assign funct  = ifidInstr[5:0];
  assign ifidRs = ifidInstr[25:21];
  assign ifidRt = ifidInstr[20:16];
  assign rd     = ifidInstr[15:11];

  regFile regs (
    .CLK(CLK), .nRST(nRST),
    .rs(ifidRs), .rt(ifidRt),
    .wbReg(wbReg), .wbWrite(wbWrite), .wbData(wbData),
    .rData1(rData1), .rData2(rData2)
  );

  assign jumpTaken  = (opcode == cpuTypesPkg::opJ);
  assign jumpTarget = {ifidPcPlus4[31:28], ifidInstr[25:0], 2'b00};
  assign haltSeen   = (opcode == cpuTypesPkg::opHalt);

  // lui gets its upper-half placement here, the alu just passes it
  assign imm = (opcode == cpuTypesPkg::opLui) ? {ifidInstr[15:0], 16'h0000}
                                               : {{16{ifidInstr[15]}}, ifidInstr[15:0]};

  always_comb
  begin
    aluCtl   = cpuTypesPkg::aluAdd;
    aluSrc   = 1'b0;
    regWrite = 1'b0;
    memToReg = 1'b0;
    dREN     = 1'b0;
    dWEN     = 1'b0;
    beq      = 1'b0;
    bne      = 1'b0;
    dst      = ifidRt;
    case (opcode)
      cpuTypesPkg::opRtype:
      begin
        regWrite = 1'b1;
        dst      = rd;
        case (funct)
          cpuTypesPkg::fnSubu: aluCtl = cpuTypesPkg::aluSub;
          cpuTypesPkg::fnAnd:  aluCtl = cpuTypesPkg::aluAnd;
          cpuTypesPkg::fnOr:   aluCtl = cpuTypesPkg::aluOr;
          cpuTypesPkg::fnSlt:  aluCtl = cpuTypesPkg::aluSlt;
          cpuTypesPkg::fnAddu: aluCtl = cpuTypesPkg::aluAdd;
          default:             regWrite = 1'b0;  // unknown funct acts as no-op
        endcase
      end
      cpuTypesPkg::opAddiu: {aluSrc, regWrite} = 2'b11;
      cpuTypesPkg::opLui:
      begin
        {aluSrc, regWrite} = 2'b11;
        aluCtl = cpuTypesPkg::aluLui;
      end
      cpuTypesPkg::opLw:    {aluSrc, regWrite, memToReg, dREN} = 4'b1111;
      cpuTypesPkg::opSw:    {aluSrc, dWEN} = 2'b11;
      cpuTypesPkg::opBeq:   beq = 1'b1;
      cpuTypesPkg::opBne:   bne = 1'b1;
      default:              ;
    endcase
  end

  // control half of ID/EX, bubbles on stall or flush
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      {idexAluSrc, idexRegWrite, idexMemToReg} <= '0;
      {idexDREN, idexDWEN, idexBeq, idexBne, idexHalt} <= '0;
      idexAluCtl <= cpuTypesPkg::aluAdd;
      idexRs     <= '0;
      idexRt     <= '0;
      idexDst    <= '0;
    end
    else if (stall || flushIdEx)
    begin
      {idexAluSrc, idexRegWrite, idexMemToReg} <= '0;
      {idexDREN, idexDWEN, idexBeq, idexBne, idexHalt} <= '0;
    end
    else
    begin
      {idexAluSrc, idexRegWrite, idexMemToReg} <= {aluSrc, regWrite, memToReg};
      {idexDREN, idexDWEN, idexBeq, idexBne, idexHalt} <= {dREN, dWEN, beq, bne, haltSeen};
      idexAluCtl <= aluCtl;
      idexRs     <= ifidRs;
      idexRt     <= ifidRt;
      idexDst    <= dst;
    end
  end

  always_ff @(posedge CLK)
  begin
    idexRdat1   <= rData1;
    idexRdat2   <= rData2;
    idexImm     <= imm;
    idexPcPlus4 <= ifidPcPlus4;
  end

endmodule

/* rtl/executeStage.sv */
// operand forwarding, alu, branch resolution and the EX/MEM register
`timescale 1ns/1ns

module executeStage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  cpuTypesPkg::aluCtlT  idexAluCtl,
  input  logic                 idexAluSrc,
  input  logic                 idexRegWrite,
  input  logic                 idexMemToReg,
  input  logic                 idexDREN,
  input  logic                 idexDWEN,
  input  logic                 idexBeq,
  input  logic                 idexBne,
  input  logic                 idexHalt,
  input  cpuTypesPkg::regAddrT idexDst,
  input  cpuTypesPkg::wordT    idexRdat1,
  input  cpuTypesPkg::wordT    idexRdat2,
  input  cpuTypesPkg::wordT    idexImm,
  input  cpuTypesPkg::wordT    idexPcPlus4,
  input  cpuTypesPkg::fwdSelT  fwdA,
  input  cpuTypesPkg::fwdSelT  fwdB,
  input  cpuTypesPkg::wordT    wbData,
  output logic                 branchTaken,
  output cpuTypesPkg::wordT    branchTarget,
  output logic                 exmemRegWrite,
  output logic                 exmemMemToReg,
  output logic                 exmemDREN,
  output logic                 exmemDWEN,
  output logic                 exmemHalt,
  output cpuTypesPkg::regAddrT exmemDst,
  output cpuTypesPkg::wordT    exmemAluResult,
  output cpuTypesPkg::wordT    exmemStoreData
);

  cpuTypesPkg::wordT opA, opB, aluB, aluResult;
  logic              equal;

  always_comb
  begin
    case (fwdA)
      cpuTypesPkg::fwdExMem: opA = exmemAluResult;
      cpuTypesPkg::fwdMemWb: opA = wbData;
      default:               opA = idexRdat1;
    endcase
    case (fwdB)
      cpuTypesPkg::fwdExMem: opB = exmemAluResult;
      cpuTypesPkg::fwdMemWb: opB = wbData;
      default:               opB = idexRdat2;
    endcase
  end

  assign aluB = idexAluSrc ? idexImm : opB;

  always_comb
  begin
    case (idexAluCtl)
      cpuTypesPkg::aluSub: aluResult = opA - aluB;
      cpuTypesPkg::aluAnd: aluResult = opA & aluB;
      cpuTypesPkg::aluOr:  aluResult = opA | aluB;
      cpuTypesPkg::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(aluB)};
      cpuTypesPkg::aluLui: aluResult = aluB;
      default:             aluResult = opA + aluB;
    endcase
  end

  // branches compare forwarded registers, never the immediate
  assign equal        = (opA == opB);
  assign branchTaken  = (idexBeq && equal) || (idexBne && !equal);
  assign branchTarget = idexPcPlus4 + {idexImm[29:0], 2'b00};

  // EX/MEM register
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      exmemRegWrite  <= 1'b0;
      exmemMemToReg  <= 1'b0;
      exmemDREN      <= 1'b0;
      exmemDWEN      <= 1'b0;
      exmemHalt      <= 1'b0;
      exmemDst       <= '0;
      exmemAluResult <= '0;
      exmemStoreData <= '0;
    end
    else
    begin
      exmemRegWrite  <= idexRegWrite;
      exmemMemToReg  <= idexMemToReg;
      exmemDREN      <= idexDREN;
      exmemDWEN      <= idexDWEN;
      exmemHalt      <= idexHalt;
      exmemDst       <= idexDst;
      exmemAluResult <= aluResult;
      exmemStoreData <= opB;  // store data sees forwarding too
    end
  end

endmodule

/* rtl/memWbStage.sv */
// data memory strobes, MEM/WB register, write-back select and halted flag
`timescale 1ns/1ns

module memWbStage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 exmemRegWrite,
  input  logic                 exmemMemToReg,
  input  logic                 exmemDREN,
  input  logic                 exmemDWEN,
  input  logic                 exmemHalt,
  input  cpuTypesPkg::regAddrT exmemDst,
  input  cpuTypesPkg::wordT    exmemAluResult,
  input  cpuTypesPkg::wordT    exmemStoreData,
  output cpuTypesPkg::wordT    dAddr,
  output cpuTypesPkg::wordT    dWData,
  input  cpuTypesPkg::wordT    dRData,
  output logic                 dREN,
  output logic                 dWEN,
  output logic                 wbWrite,
  output cpuTypesPkg::regAddrT wbReg,
  output cpuTypesPkg::wordT    wbData,
  output cpuTypesPkg::regAddrT memwbDst,
  output logic                 memwbRegWrite,
  output logic                 halted
);

  logic              memwbMemToReg;
  cpuTypesPkg::wordT memwbRData, memwbAluResult;

  assign dAddr  = exmemAluResult;
  assign dWData = exmemStoreData;
  assign dREN   = exmemDREN;
  assign dWEN   = exmemDWEN;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      memwbRegWrite <= 1'b0;
      memwbMemToReg <= 1'b0;
      memwbDst      <= '0;
      halted        <= 1'b0;
    end
    else
    begin
      memwbRegWrite <= exmemRegWrite;
      memwbMemToReg <= exmemMemToReg;
      memwbDst      <= exmemDst;
      halted        <= halted || exmemHalt;  // sticky until reset
    end
  end

  always_ff @(posedge CLK)
  begin
    memwbRData     <= dRData;
    memwbAluResult <= exmemAluResult;
  end

  assign wbWrite = memwbRegWrite;
  assign wbReg   = memwbDst;
  assign wbData  = memwbMemToReg ? memwbRData : memwbAluResult;

endmodule

/* rtl/hazardUnit.sv */
// forwarding selects, load-use stall and flush decisions
`timescale 1ns/1ns

module hazardUnit (
  input  cpuTypesPkg::regAddrT ifidRs,
  input  cpuTypesPkg::regAddrT ifidRt,
  input  cpuTypesPkg::regAddrT idexRs,
  input  cpuTypesPkg::regAddrT idexRt,
  input  cpuTypesPkg::regAddrT idexDst,
  input  cpuTypesPkg::regAddrT exmemDst,
  input  cpuTypesPkg::regAddrT memwbDst,
  input  logic                 idexDREN,
  input  logic                 exmemRegWrite,
  input  logic                 memwbRegWrite,
  input  logic                 jumpTaken,
  input  logic                 branchTaken,
  output cpuTypesPkg::fwdSelT  fwdA,
  output cpuTypesPkg::fwdSelT  fwdB,
  output logic                 stall,
  output logic                 flushIfId,
  output logic                 flushIdEx
);

  // younger EX/MEM result wins over MEM/WB
  function automatic cpuTypesPkg::fwdSelT pickSource(cpuTypesPkg::regAddrT src);
    cpuTypesPkg::fwdSelT sel;
    sel = cpuTypesPkg::fwdNone;
    if (src != '0)
    begin
      if (exmemRegWrite && exmemDst == src)
        sel = cpuTypesPkg::fwdExMem;
      else if (memwbRegWrite && memwbDst == src)
        sel = cpuTypesPkg::fwdMemWb;
    end
    return sel;
  endfunction

  always_comb
  begin
    fwdA = pickSource(idexRs);
    fwdB = pickSource(idexRt);
  end

  // load in EX feeding the instruction in decode
  assign stall = idexDREN && (idexDst != '0) &&
                 (idexDst == ifidRs || idexDst == ifidRt);

  assign flushIfId = branchTaken || (jumpTaken && !stall);  // stalled jump retries
  assign flushIdEx = branchTaken;

endmodule

/* rtl/pipelineCpu.sv */
// top level of the five-stage pipelined cpu
// connects fetch, decode, execute, memory/write-back and hazard unit
`timescale 1ns/1ns

module pipelineCpu #(
  parameter cpuTypesPkg::wordT resetPc = '0
) (
  input  logic              CLK,
  input  logic              nRST,
  output cpuTypesPkg::wordT iAddr,
  input  cpuTypesPkg::wordT iData,
  output cpuTypesPkg::wordT dAddr,
  output cpuTypesPkg::wordT dWData,
  input  cpuTypesPkg::wordT dRData,
  output logic              dREN,
  output logic              dWEN,
  output logic              halted
);

  cpuTypesPkg::wordT    ifidInstr, ifidPcPlus4, jumpTarget, branchTarget;
  cpuTypesPkg::regAddrT ifidRs, ifidRt;
  logic                 stall, flushIfId, flushIdEx, jumpTaken, branchTaken, haltSeen;
  cpuTypesPkg::fwdSelT  fwdA, fwdB;

  cpuTypesPkg::aluCtlT  idexAluCtl;
  logic                 idexAluSrc, idexRegWrite, idexMemToReg, idexDREN, idexDWEN;
  logic                 idexBeq, idexBne, idexHalt;
  cpuTypesPkg::regAddrT idexRs, idexRt, idexDst;
  cpuTypesPkg::wordT    idexRdat1, idexRdat2, idexImm, idexPcPlus4;

  logic                 exmemRegWrite, exmemMemToReg, exmemDREN, exmemDWEN, exmemHalt;
  cpuTypesPkg::regAddrT exmemDst;
  cpuTypesPkg::wordT    exmemAluResult, exmemStoreData;

  logic                 wbWrite, memwbRegWrite;
  cpuTypesPkg::regAddrT wbReg, memwbDst;
  cpuTypesPkg::wordT    wbData;

  fetchStage #(.resetPc(resetPc)) fetch (
    .CLK(CLK), .nRST(nRST), .iAddr(iAddr), .iData(iData),
    .stall(stall), .flushIfId(flushIfId), .jumpTaken(jumpTaken),
    .branchTaken(branchTaken), .haltSeen(haltSeen),
    .jumpTarget(jumpTarget), .branchTarget(branchTarget),
    .ifidInstr(ifidInstr), .ifidPcPlus4(ifidPcPlus4)
  );

  decodeStage decode (
    .CLK(CLK), .nRST(nRST), .ifidInstr(ifidInstr), .ifidPcPlus4(ifidPcPlus4),
    .stall(stall), .flushIdEx(flushIdEx),
    .wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData),
    .ifidRs(ifidRs), .ifidRt(ifidRt), .jumpTaken(jumpTaken), .haltSeen(haltSeen),
    .jumpTarget(jumpTarget), .idexAluCtl(idexAluCtl), .idexAluSrc(idexAluSrc),
    .idexRegWrite(idexRegWrite), .idexMemToReg(idexMemToReg),
    .idexDREN(idexDREN), .idexDWEN(idexDWEN), .idexBeq(idexBeq), .idexBne(idexBne),
    .idexHalt(idexHalt), .idexRs(idexRs), .idexRt(idexRt), .idexDst(idexDst),
    .idexRdat1(idexRdat1), .idexRdat2(idexRdat2), .idexImm(idexImm),
    .idexPcPlus4(idexPcPlus4)
  );

  executeStage execute (
    .CLK(CLK), .nRST(nRST), .idexAluCtl(idexAluCtl), .idexAluSrc(idexAluSrc),
    .idexRegWrite(idexRegWrite), .idexMemToReg(idexMemToReg),
    .idexDREN(idexDREN), .idexDWEN(idexDWEN), .idexBeq(idexBeq), .idexBne(idexBne),
    .idexHalt(idexHalt), .idexDst(idexDst), .idexRdat1(idexRdat1),
    .idexRdat2(idexRdat2), .idexImm(idexImm), .idexPcPlus4(idexPcPlus4),
    .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .exmemRegWrite(exmemRegWrite), .exmemMemToReg(exmemMemToReg),
    .exmemDREN(exmemDREN), .exmemDWEN(exmemDWEN), .exmemHalt(exmemHalt),
    .exmemDst(exmemDst), .exmemAluResult(exmemAluResult),
    .exmemStoreData(exmemStoreData)
  );

  memWbStage memWb (
    .CLK(CLK), .nRST(nRST), .exmemRegWrite(exmemRegWrite),
    .exmemMemToReg(exmemMemToReg), .exmemDREN(exmemDREN), .exmemDWEN(exmemDWEN),
    .exmemHalt(exmemHalt), .exmemDst(exmemDst), .exmemAluResult(exmemAluResult),
    .exmemStoreData(exmemStoreData), .dAddr(dAddr), .dWData(dWData),
    .dRData(dRData), .dREN(dREN), .dWEN(dWEN),
    .wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData),
    .memwbDst(memwbDst), .memwbRegWrite(memwbRegWrite), .halted(halted)
  );

  hazardUnit hazard (
    .ifidRs(ifidRs), .ifidRt(ifidRt), .idexRs(idexRs), .idexRt(idexRt),
    .idexDst(idexDst), .exmemDst(exmemDst), .memwbDst(memwbDst),
    .idexDREN(idexDREN), .exmemRegWrite(exmemRegWrite),
    .memwbRegWrite(memwbRegWrite), .jumpTaken(jumpTaken), .branchTaken(branchTaken),
    .fwdA(fwdA), .fwdB(fwdB), .stall(stall),
    .flushIfId(flushIfId), .flushIdEx(flushIdEx)
  );

endmodule

/* sim/pipelineCpu_sva.sv */
// pipeline assertions for the cpu top level, attached with bind
`timescale 1ns/1ns

module pipelineCpuSva (
  input logic              CLK,
  input logic              nRST,
  input cpuTypesPkg::wordT iAddr,
  input logic              dREN,
  input logic              dWEN,
  input logic              halted
);

  // one data access per cycle
  noReadWithWrite: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
    else $error("dREN and dWEN are high in the same cycle");

  haltedSticky: assert property (@(posedge CLK) disable iff (!nRST) halted |=> halted)
    else $error("halted fell while nRST was high");

  // fetch is frozen well before halted shows up
  fetchFrozen: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(halted) |=> $stable(iAddr))
    else $error("iAddr moved in the cycle after halted rose");

endmodule

bind pipelineCpu pipelineCpuSva sva (
  .CLK(CLK), .nRST(nRST), .iAddr(iAddr),
  .dREN(dREN), .dWEN(dWEN), .halted(halted)
);

/* sim/pipelineCpuTb.sv */
// cpu testbench with clock, reset, memory models and lfsr operands
// directed program tests and the final report
`timescale 1ns/1ns

module pipelineCpuTb;

  localparam cpuTypesPkg::wordT resetPc = 32'h0000_0040;
  localparam int memWords = 256;
  localparam int progBase = resetPc / 4;

  logic              CLK;
  logic              nRST;
  cpuTypesPkg::wordT iAddr, iData, dAddr, dWData, dRData;
  logic              dREN, dWEN, halted;

  cpuTypesPkg::wordT imem [memWords];
  cpuTypesPkg::wordT dmem [memWords];
  cpuTypesPkg::wordT prog [$];  // program being assembled
  cpuTypesPkg::wordT lfsr = 32'h1f71_14fd;
  int                errors = 0;
  string             testName = "init";

  pipelineCpu #(.resetPc(resetPc)) dut (
    .CLK(CLK), .nRST(nRST), .iAddr(iAddr), .iData(iData),
    .dAddr(dAddr), .dWData(dWData), .dRData(dRData),
    .dREN(dREN), .dWEN(dWEN), .halted(halted)
  );

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  assign iData  = imem[iAddr[9:2]];  // same-cycle fetch
  assign dRData = dmem[dAddr[9:2]];

  always @(posedge CLK)
  begin
    if (dWEN)
      dmem[dAddr[9:2]] <= dWData;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic cpuTypesPkg::wordT randBits(int n);
    cpuTypesPkg::wordT w;
    w = '0;
    for (int i = 0; i < n; i++)
      w = {w[30:0], lfsrStep()};
    return w;
  endfunction

  // untouched data words depend on every address bit
  function automatic cpuTypesPkg::wordT fillPattern(cpuTypesPkg::wordT addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic cpuTypesPkg::wordT encR(cpuTypesPkg::functT fn, cpuTypesPkg::regAddrT rd,
                                             cpuTypesPkg::regAddrT rs, cpuTypesPkg::regAddrT rt);
    return {cpuTypesPkg::opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic cpuTypesPkg::wordT encI(cpuTypesPkg::opcodeT op, cpuTypesPkg::regAddrT rt,
                                             cpuTypesPkg::regAddrT rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic emitR(cpuTypesPkg::functT fn, cpuTypesPkg::regAddrT rd,
                       cpuTypesPkg::regAddrT rs, cpuTypesPkg::regAddrT rt);
    prog.push_back(encR(fn, rd, rs, rt));
  endtask

  task automatic emitI(cpuTypesPkg::opcodeT op, cpuTypesPkg::regAddrT rt,
                       cpuTypesPkg::regAddrT rs, logic [15:0] imm);
    prog.push_back(encI(op, rt, rs, imm));
  endtask

  task automatic emitJump(cpuTypesPkg::wordT target);
    prog.push_back({cpuTypesPkg::opJ, target[27:2]});
  endtask

  task automatic emitHalt();
    prog.push_back({cpuTypesPkg::opHalt, 26'd0});
  endtask

  task automatic emitStore(cpuTypesPkg::regAddrT rt, logic [15:0] offset);
    emitI(cpuTypesPkg::opSw, rt, 5'd0, offset);  // base is r0
  endtask

  // lui upper half is corrected for the sign-extended addiu low half
  task automatic loadConst(cpuTypesPkg::regAddrT r, cpuTypesPkg::wordT v);
    logic [15:0] hi;
    hi = v[31:16] + {15'd0, v[15]};
    emitI(cpuTypesPkg::opLui, r, 5'd0, hi);
    emitI(cpuTypesPkg::opAddiu, r, r, v[15:0]);
  endtask

  task automatic checkWord(string what, cpuTypesPkg::wordT expected, cpuTypesPkg::wordT actual);
    if (actual !== expected)
    begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkBit(string what, logic expected, logic actual);
    if (actual !== expected)
    begin
      errors++;
      $display("FAILED %s %s: expected %b, actual %b", testName, what, expected, actual);
    end
  endtask

  task automatic checkMem(string what, cpuTypesPkg::wordT addr, cpuTypesPkg::wordT expected);
    checkWord(what, expected, dmem[addr[9:2]]);
  endtask

  task automatic fillMemories();
    for (int i = 0; i < memWords; i++)
    begin
      imem[8'(i)] = '0;  // no-op
      dmem[8'(i)] = fillPattern(cpuTypesPkg::wordT'(i) << 2);
    end
    for (int k = 0; k < prog.size(); k++)
      imem[8'(progBase + k)] = prog[k];
  endtask

  task automatic checkResetState();
    checkBit("dREN in reset", 1'b0, dREN);
    checkBit("dWEN in reset", 1'b0, dWEN);
    checkBit("halted in reset", 1'b0, halted);
    checkWord("iAddr in reset", resetPc, iAddr);
  endtask

  // reset for 5 cycles while the memories are loaded
  task automatic resetAndLoad();
    @(negedge CLK);
    nRST = 1'b0;
    fillMemories();
    #1 checkResetState();
    repeat (5)
    begin
      @(negedge CLK);
      checkResetState();
    end
    nRST = 1'b1;
    #1 checkResetState();
  endtask

  task automatic waitHalted(output int cycles);
    cycles = 0;
    while (halted !== 1'b1 && cycles < 200)
    begin
      @(negedge CLK);
      cycles++;
    end
    if (halted !== 1'b1)
    begin
      errors++;
      $display("%s: halted did not rise within 200 cycles", testName);
    end
  endtask

  task automatic testAlu();
    cpuTypesPkg::wordT a, b;
    logic [15:0]       imm;
    int                cycles;
    testName = "testAlu";
    a = randBits(32);
    b = randBits(32);
    imm = 16'(randBits(16));
    prog.delete();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    emitR(cpuTypesPkg::fnAddu, 5'd3, 5'd1, 5'd2);
    emitStore(5'd3, 16'h0000);
    emitR(cpuTypesPkg::fnSubu, 5'd4, 5'd1, 5'd2);
    emitStore(5'd4, 16'h0004);
    emitR(cpuTypesPkg::fnAnd, 5'd5, 5'd1, 5'd2);
    emitStore(5'd5, 16'h0008);
    emitR(cpuTypesPkg::fnOr, 5'd6, 5'd1, 5'd2);
    emitStore(5'd6, 16'h000c);
    emitR(cpuTypesPkg::fnSlt, 5'd7, 5'd1, 5'd2);
    emitStore(5'd7, 16'h0010);
    emitR(cpuTypesPkg::fnSlt, 5'd8, 5'd2, 5'd1);  // operands swapped
    emitStore(5'd8, 16'h0014);
    emitI(cpuTypesPkg::opAddiu, 5'd9, 5'd1, imm);
    emitStore(5'd9, 16'h0018);
    emitI(cpuTypesPkg::opLui, 5'd10, 5'd0, imm);
    emitStore(5'd10, 16'h001c);
    emitHalt();
    resetAndLoad();
    waitHalted(cycles);
    checkMem("addu", 32'h00, a + b);
    checkMem("subu", 32'h04, a - b);
    checkMem("and", 32'h08, a & b);
    checkMem("or", 32'h0c, a | b);
    checkMem("slt a<b", 32'h10, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    checkMem("slt b<a", 32'h14, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    checkMem("addiu", 32'h18, a + {{16{imm[15]}}, imm});
    checkMem("lui", 32'h1c, {imm, 16'h0000});
  endtask

  task automatic testForward();
    cpuTypesPkg::wordT a, b, s3, s4, s5, s6, r7;
    int                cycles;
    testName = "testForward";
    a = randBits(32);
    b = randBits(32);
    prog.delete();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    emitR(cpuTypesPkg::fnAddu, 5'd3, 5'd1, 5'd2);
    emitR(cpuTypesPkg::fnAddu, 5'd4, 5'd3, 5'd2);
    emitR(cpuTypesPkg::fnAddu, 5'd5, 5'd4, 5'd3);  // both forwarding paths at once
    emitR(cpuTypesPkg::fnAddu, 5'd6, 5'd5, 5'd4);
    emitR(cpuTypesPkg::fnAddu, 5'd7, 5'd1, 5'd1);
    emitR(cpuTypesPkg::fnAddu, 5'd7, 5'd7, 5'd2);
    emitR(cpuTypesPkg::fnAddu, 5'd8, 5'd7, 5'd7);  // newest r7 must win
    for (int r = 3; r <= 8; r++)
      emitStore(5'(r), 16'((r - 3) * 4));
    emitHalt();
    resetAndLoad();
    waitHalted(cycles);
    s3 = a + b;
    s4 = s3 + b;
    s5 = s4 + s3;
    s6 = s5 + s4;
    r7 = a + a + b;
    checkMem("sum r3", 32'h00, s3);
    checkMem("sum r4", 32'h04, s4);
    checkMem("sum r5", 32'h08, s5);
    checkMem("sum r6", 32'h0c, s6);
    checkMem("rewrite r7", 32'h10, r7);
    checkMem("double r7", 32'h14, r7 + r7);
  endtask

  task automatic testLoadUse();
    cpuTypesPkg::wordT b;
    int                cycles;
    testName = "testLoadUse";
    b = randBits(32);
    prog.delete();
    loadConst(5'd2, b);
    emitI(cpuTypesPkg::opLw, 5'd1, 5'd0, 16'h0080);
    emitR(cpuTypesPkg::fnAddu, 5'd3, 5'd1, 5'd2);  // loaded value on rs
    emitStore(5'd3, 16'h0000);
    emitI(cpuTypesPkg::opLw, 5'd4, 5'd0, 16'h0084);
    emitR(cpuTypesPkg::fnAddu, 5'd5, 5'd2, 5'd4);  // loaded value on rt
    emitStore(5'd5, 16'h0004);
    emitI(cpuTypesPkg::opLw, 5'd6, 5'd0, 16'h0088);
    emitStore(5'd6, 16'h0008);
    emitHalt();
    resetAndLoad();
    waitHalted(cycles);
    checkMem("lw then addu rs", 32'h00, fillPattern(32'h80) + b);
    checkMem("lw then addu rt", 32'h04, b + fillPattern(32'h84));
    checkMem("lw then sw", 32'h08, fillPattern(32'h88));
  endtask

  task automatic testBranchJump();
    cpuTypesPkg::wordT a, b, target;
    int                cycles;
    testName = "testBranchJump";
    a = randBits(32);
    b = a ^ (randBits(32) | 32'd1);  // always differs from a
    prog.delete();
    loadConst(5'd1, a);
    loadConst(5'd2, a);
    loadConst(5'd3, b);
    emitI(cpuTypesPkg::opBeq, 5'd2, 5'd1, 16'd2);  // taken
    emitStore(5'd1, 16'h0000);
    emitStore(5'd1, 16'h0004);
    emitStore(5'd1, 16'h0008);
    emitI(cpuTypesPkg::opBeq, 5'd3, 5'd1, 16'd1);  // not taken
    emitStore(5'd3, 16'h000c);
    emitI(cpuTypesPkg::opBne, 5'd3, 5'd1, 16'd1);  // taken
    emitStore(5'd1, 16'h0010);
    emitStore(5'd3, 16'h0014);
    emitI(cpuTypesPkg::opBne, 5'd2, 5'd1, 16'd1);  // not taken
    emitStore(5'd2, 16'h0018);
    target = resetPc + (cpuTypesPkg::wordT'(prog.size() + 2) << 2);
    emitJump(target);
    emitStore(5'd1, 16'h001c);
    emitStore(5'd3, 16'h0020);
    emitHalt();
    resetAndLoad();
    waitHalted(cycles);
    checkMem("beq skipped 1", 32'h00, fillPattern(32'h00));
    checkMem("beq skipped 2", 32'h04, fillPattern(32'h04));
    checkMem("beq target", 32'h08, a);
    checkMem("beq fall-through", 32'h0c, b);
    checkMem("bne skipped", 32'h10, fillPattern(32'h10));
    checkMem("bne target", 32'h14, b);
    checkMem("bne fall-through", 32'h18, a);
    checkMem("j skipped", 32'h1c, fillPattern(32'h1c));
    checkMem("j target", 32'h20, b);
  endtask

  task automatic testHalt();
    logic [15:0] imm;
    int          cycles;
    testName = "testHalt";
    imm = 16'(randBits(16));
    prog.delete();
    emitI(cpuTypesPkg::opAddiu, 5'd1, 5'd0, imm);
    emitStore(5'd1, 16'h0000);
    emitHalt();  // index 2
    emitStore(5'd1, 16'h0004);
    emitStore(5'd1, 16'h0008);
    resetAndLoad();
    waitHalted(cycles);
    checkWord("halted latency", 32'd6, cpuTypesPkg::wordT'(cycles));  // fetch index plus 4
    repeat (10)
    begin
      @(negedge CLK);
      checkBit("halted held", 1'b1, halted);
      checkWord("iAddr frozen", resetPc + 32'd12, iAddr);
    end
    // stores behind the halt would have reached memory by now
    checkMem("store before halt", 32'h00, {{16{imm[15]}}, imm});
    checkMem("store after halt 1", 32'h04, fillPattern(32'h04));
    checkMem("store after halt 2", 32'h08, fillPattern(32'h08));
  endtask

  task automatic testReset();
    cpuTypesPkg::wordT a;
    int                cycles;
    testName = "testReset";
    a = randBits(32);
    prog.delete();
    loadConst(5'd1, a);
    emitStore(5'd1, 16'h0040);
    emitI(cpuTypesPkg::opLw, 5'd2, 5'd0, 16'h0040);
    emitR(cpuTypesPkg::fnAddu, 5'd3, 5'd2, 5'd1);
    emitStore(5'd3, 16'h0044);
    emitHalt();
    resetAndLoad();
    waitHalted(cycles);
    checkMem("first run store", 32'h40, a);
    checkMem("first run sum", 32'h44, a + a);
    // reset again from the halted state and rerun
    resetAndLoad();
    waitHalted(cycles);
    checkMem("second run store", 32'h40, a);
    checkMem("second run sum", 32'h44, a + a);
  endtask

  initial
  begin
    nRST = 1'b0;
    prog.delete();
    fillMemories();
    testAlu();
    testForward();
    testLoadUse();
    testBranchJump();
    testHalt();
    testReset();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* flist.f */
rtl/cpuTypesPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/hazardUnit.sv
rtl/pipelineCpu.sv
sim/pipelineCpu_sva.sv
sim/pipelineCpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile the cpu testbench with verilator, run it and check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module pipelineCpuTb -f flist.f
./obj_dir/VpipelineCpuTb 2>&1 | tee sim.log

if grep -q "^Test OK$" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
